// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert --timescale 1ns/1ps
TOP       = tb_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG  = test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/cpu11_assertions.sv ====
module cpu11_assertions import cpu11_pkg::*; #(
    parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
    input logic  clk,
    input logic  reset_n,
    input logic  rd_req_i,
    input word_t rd_addr_i,
    input logic  rd_ready_i,
    input logic  push_i,
    input logic  credit_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int credits;           // shadow of the fetch credit counter
    int stable_fails = 0;
    int gap_fails    = 0;
    int credit_fails = 0;
    int push_fails   = 0;

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credits <= QUEUE_DEPTH;
        end else begin
            credits <= credits - int'(push_i) + int'(credit_i);
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!reset_n)
        rd_req_i && !rd_ready_i |=> rd_req_i && $stable(rd_addr_i)) else begin
        $error("read request or address changed before the reply");
        stable_fails++;
    end

    // request must be low for a cycle after each reply
    reply_gap: assert property (@(posedge clk) disable iff (!reset_n)
        rd_req_i && rd_ready_i |=> !rd_req_i) else begin
        $error("read request still high in the cycle after the reply");
        gap_fails++;
    end

    credit_range: assert property (@(posedge clk) disable iff (!reset_n)
        credits >= 0 && credits <= QUEUE_DEPTH) else begin
        $error("credit count %0d outside 0..%0d", credits, QUEUE_DEPTH);
        credit_fails++;
    end

    push_needs_credit: assert property (@(posedge clk) disable iff (!reset_n)
        push_i |-> credits > 0) else begin
        $error("push into the queue with no credit left");
        push_fails++;
    end

endmodule

bind cpu11_top cpu11_assertions #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) u_assert (
    .clk        (clk),
    .reset_n    (reset_n),
    .rd_req_i   (rd_req_o),
    .rd_addr_i  (rd_addr_o),
    .rd_ready_i (rd_ready_i),
    .push_i     (push),
    .credit_i   (credit)
);

// ==== dv/patterns_cpu11.txt ====
# I <word, octal> : program word, in address order from octal 1000
# R <reg> <data, octal> <NZC, binary> : result ; R - <NZC> : flags only ; X : illegal word
I 005200
R 0 000001 000
I 005301
R 1 177777 100
I 005102
R 2 177777 101
I 005400
R 0 177777 101
I 005003
R 3 000000 010
I 005204
R 4 000001 000
I 060401
R 1 000000 011
I 160403
R 3 177777 101
I 010405
R 5 000001 001
I 005701
R - 011
I 020402
R - 001
I 030401
R - 011
I 040402
R 2 177776 101
I 050401
R 1 000001 001
I 011102
X
I 070102
X
I 005201
R 1 000002 001

// ==== dv/tb_checker.sv ====
module tb_checker import cpu11_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     res_valid_i,
    input  logic     res_wr_i,
    input  reg_idx_t res_reg_i,
    input  word_t    res_data_i,
    input  flags_t   res_flags_i,
    input  logic     illegal_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // kind 0 register write, 1 flags only, 2 illegal
    int       exp_kind  [$];
    reg_idx_t exp_reg   [$];
    word_t    exp_data  [$];
    flags_t   exp_flags [$];
    int       seen   = 0;
    int       errors = 0;

    task automatic add_event(input int kind, input reg_idx_t r, input word_t d, input flags_t f);
        exp_kind.push_back(kind);
        exp_reg.push_back(r);
        exp_data.push_back(d);
        exp_flags.push_back(f);
    endtask

    function automatic int event_count();
        return seen;
    endfunction

    function automatic int expected_count();
        return exp_kind.size();
    endfunction

    function automatic int error_count();
        return errors;
    endfunction

    task automatic mismatch(input string msg);
        errors++;
        $display("error %0t: event %0d %s", $time, seen, msg);
    endtask

    task automatic check_missing();
        if (seen < exp_kind.size()) begin
            $display("missing %0d of %0d expected events", exp_kind.size() - seen,
                     exp_kind.size());
            errors += exp_kind.size() - seen;
        end
    endtask

    // ========================================
    // in-order event compare
    // ========================================

    always @(posedge clk) begin
        if (reset_n && (res_valid_i || illegal_i)) begin
            if (seen >= exp_kind.size()) begin
                errors++;
                $display("unexpected event at %0t after all expected events", $time);
            end else if (res_valid_i && illegal_i) begin
                mismatch("result and illegal in the same cycle");
            end else if (exp_kind[seen] == 2) begin
                if (!illegal_i) mismatch($sformatf("expected illegal, got R%0d=%06o",
                                                   res_reg_i, res_data_i));
            end else if (illegal_i) begin
                mismatch("expected a result, got illegal");
            end else begin
                if (res_wr_i != (exp_kind[seen] == 0))
                    mismatch($sformatf("write flag %0b wrong", res_wr_i));
                if (exp_kind[seen] == 0 && (res_reg_i != exp_reg[seen]
                                            || res_data_i != exp_data[seen]))
                    mismatch($sformatf("got R%0d=%06o, expected R%0d=%06o", res_reg_i,
                                       res_data_i, exp_reg[seen], exp_data[seen]));
                if (res_flags_i != exp_flags[seen])
                    mismatch($sformatf("flags %03b, expected %03b", res_flags_i,
                                       exp_flags[seen]));
            end
            seen++;
        end
    end

endmodule

// ==== dv/tb_top.sv ====
module tb_top import cpu11_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic     clk = 1'b0;
    logic     reset_n;
    logic     rd_req;
    word_t    rd_addr;
    logic     rd_ready_i;
    word_t    rd_data_i;
    logic     res_valid;
    logic     res_wr;
    reg_idx_t res_reg;
    word_t    res_data;
    flags_t   res_flags;
    logic     illegal;

    word_t    prog [$];      // program image from octal 1000 upwards
    int       mem_idx;
    int       delay_left;
    int       limit;
    int       cycles;
    int       tb_errors = 0;
    int       assert_fails;
    int       total;

    always #20 clk = ~clk;

    cpu11_top u_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .rd_req_o    (rd_req),
        .rd_addr_o   (rd_addr),
        .rd_ready_i  (rd_ready_i),
        .rd_data_i   (rd_data_i),
        .res_valid_o (res_valid),
        .res_wr_o    (res_wr),
        .res_reg_o   (res_reg),
        .res_data_o  (res_data),
        .res_flags_o (res_flags),
        .illegal_o   (illegal)
    );

    tb_checker u_check (
        .clk         (clk),
        .reset_n     (reset_n),
        .res_valid_i (res_valid),
        .res_wr_i    (res_wr),
        .res_reg_i   (res_reg),
        .res_data_i  (res_data),
        .res_flags_i (res_flags),
        .illegal_i   (illegal)
    );

    // ========================================
    // memory model
    // ========================================

    assign mem_idx = (int'(rd_addr) - int'(BOOT_ADDR_DEF)) / 2;

    // no reply past the program, so fetch stalls there
    always @(posedge clk) begin
        if (rd_ready_i) begin
            rd_ready_i <= 1'b0;                  // one cycle reply
        end else if (rd_req && mem_idx >= 0 && mem_idx < prog.size()) begin
            if (delay_left == 0) begin
                rd_ready_i <= 1'b1;
                rd_data_i  <= prog[mem_idx];
                delay_left <= $urandom_range(3, 0);
            end else begin
                delay_left <= delay_left - 1;
            end
        end
    end

    task automatic load_patterns();
        int    fd;
        string line;
        int    r;
        int    v;
        int    f;
        fd = $fopen("dv/patterns_cpu11.txt", "r");
        if (fd == 0) begin
            $display("cannot open pattern file dv/patterns_cpu11.txt");
            tb_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            if (line.getc(0) == "I" && $sscanf(line, "I %o", v) == 1) begin
                prog.push_back(word_t'(v));
            end else if (line.getc(0) == "R" && line.getc(2) == "-"
                         && $sscanf(line, "R - %b", f) == 1) begin
                u_check.add_event(1, '0, '0, flags_t'(f));
            end else if (line.getc(0) == "R" && $sscanf(line, "R %d %o %b", r, v, f) == 3) begin
                u_check.add_event(0, reg_idx_t'(r), word_t'(v), flags_t'(f));
            end else if (line.getc(0) == "X") begin
                u_check.add_event(2, '0, '0, '0);
            end else begin
                $display("pattern line not understood: %s", line);
                tb_errors++;
            end
        end
        $fclose(fd);
        if (prog.size() == 0) begin
            $display("pattern file holds no program words");
            tb_errors++;
        end
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial begin
        reset_n    <= 1'b0;
        rd_ready_i <= 1'b0;
        rd_data_i  <= '0;
        void'($urandom(74));
        delay_left <= $urandom_range(3, 0);
        load_patterns();
        limit = 10 * prog.size() + 100;

        repeat (10) @(posedge clk);
        reset_n <= 1'b1;

        cycles = 0;
        while (u_check.event_count() < u_check.expected_count() && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d events seen",
                     cycles, u_check.event_count(), u_check.expected_count());
            tb_errors++;
        end

        repeat (20) @(posedge clk);             // catch late or extra events
        u_check.check_missing();
        assert_fails = u_dut.u_assert.stable_fails + u_dut.u_assert.gap_fails
                     + u_dut.u_assert.credit_fails + u_dut.u_assert.push_fails;
        total = tb_errors + u_check.error_count() + assert_fails;
        $display("events %0d of %0d, checker errors %0d, assertion failures %0d, other %0d",
                 u_check.event_count(), u_check.expected_count(), u_check.error_count(),
                 assert_fails, tb_errors);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/cpu11_pkg.sv
rtl/insn_fetch.sv
rtl/insn_queue.sv
rtl/insn_exec.sv
rtl/cpu11_top.sv
dv/cpu11_assertions.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== rtl/cpu11_pkg.sv ====
package cpu11_pkg;

    // ========================================
    // basic types
    // ========================================

    typedef logic [15:0] word_t;     // instruction, address or data word
    typedef logic [2:0]  reg_idx_t;  // R0..R7
    typedef logic [2:0]  flags_t;    // {N, Z, C}

    // bit positions inside flags_t
    localparam int FLAG_N = 2;
    localparam int FLAG_Z = 1;
    localparam int FLAG_C = 0;

    // ========================================
    // defaults for the top level
    // ========================================

    localparam int    QUEUE_DEPTH_DEF = 4;
    localparam word_t BOOT_ADDR_DEF   = 16'o001000;

    // ========================================
    // opcode fields
    // ========================================

    // double operand group, bits 15:12
    localparam logic [3:0] DOP_SOP = 4'o00;  // single operand space
    localparam logic [3:0] DOP_MOV = 4'o01;
    localparam logic [3:0] DOP_CMP = 4'o02;
    localparam logic [3:0] DOP_BIT = 4'o03;
    localparam logic [3:0] DOP_BIC = 4'o04;
    localparam logic [3:0] DOP_BIS = 4'o05;
    localparam logic [3:0] DOP_ADD = 4'o06;
    localparam logic [3:0] DOP_SUB = 4'o16;

    // single operand group, bits 11:6 when bits 15:12 are zero
    localparam logic [5:0] SOP_CLR = 6'o50;
    localparam logic [5:0] SOP_COM = 6'o51;
    localparam logic [5:0] SOP_INC = 6'o52;
    localparam logic [5:0] SOP_DEC = 6'o53;
    localparam logic [5:0] SOP_NEG = 6'o54;
    localparam logic [5:0] SOP_TST = 6'o57;

    // decoded operation, register mode only
    typedef enum logic [3:0] {
        OP_CLR,
        OP_COM,
        OP_INC,
        OP_DEC,
        OP_NEG,
        OP_TST,
        OP_MOV,
        OP_CMP,
        OP_BIT,
        OP_BIC,
        OP_BIS,
        OP_ADD,
        OP_SUB,
        OP_ILL   // anything not listed above
    } op_e;

endpackage

// ==== rtl/cpu11_top.sv ====
module cpu11_top import cpu11_pkg::*; #(
    parameter int    QUEUE_DEPTH = QUEUE_DEPTH_DEF,
    parameter word_t BOOT_ADDR   = BOOT_ADDR_DEF
) (
    input  logic     clk,
    input  logic     reset_n,

    // memory read bus
    output logic     rd_req_o,
    output word_t    rd_addr_o,
    input  logic     rd_ready_i,
    input  word_t    rd_data_i,

    // execution results
    output logic     res_valid_o,
    output logic     res_wr_o,
    output reg_idx_t res_reg_o,
    output word_t    res_data_o,
    output flags_t   res_flags_o,
    output logic     illegal_o
);

    logic  push;
    word_t push_data;
    logic  credit;
    logic  q_valid;
    word_t q_data;
    logic  pop;

    // ========================================
    // fetch -> queue -> execute
    // ========================================

    insn_fetch #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .BOOT_ADDR   (BOOT_ADDR)
    ) u_fetch (
        .clk         (clk),
        .reset_n     (reset_n),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .rd_ready_i  (rd_ready_i),
        .rd_data_i   (rd_data_i),
        .push_o      (push),
        .push_data_o (push_data),
        .credit_i    (credit)
    );

    insn_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk         (clk),
        .reset_n     (reset_n),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .q_valid_o   (q_valid),
        .q_data_o    (q_data),
        .credit_o    (credit)
    );

    insn_exec u_exec (
        .clk         (clk),
        .reset_n     (reset_n),
        .q_valid_i   (q_valid),
        .q_data_i    (q_data),
        .pop_o       (pop),
        .res_valid_o (res_valid_o),
        .res_wr_o    (res_wr_o),
        .res_reg_o   (res_reg_o),
        .res_data_o  (res_data_o),
        .res_flags_o (res_flags_o),
        .illegal_o   (illegal_o)
    );

endmodule

// ==== rtl/insn_exec.sv ====
module insn_exec import cpu11_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,

    // from the queue
    input  logic     q_valid_i,
    input  word_t    q_data_i,
    output logic     pop_o,

    // results
    output logic     res_valid_o,
    output logic     res_wr_o,
    output reg_idx_t res_reg_o,
    output word_t    res_data_o,
    output flags_t   res_flags_o,
    output logic     illegal_o
);

    // decode stage
    logic     ir_valid_q;
    word_t    ir_q;
    op_e      dec_op;
    logic     is_dop;
    logic     mode_ok;

    // execute stage
    logic     ex_valid_q;
    op_e      ex_op_q;
    reg_idx_t ex_src_q;
    reg_idx_t ex_dst_q;

    word_t    regs [8];
    flags_t   flags_q;
    word_t    src_val;
    word_t    dst_val;
    word_t    alu_res;
    logic     [16:0] alu_wide;    // carry or borrow in bit 16
    logic     c_new;
    logic     wr_en;
    logic     legal;

    assign pop_o = q_valid_i;     // never stalls

    // ========================================
    // decode
    // ========================================

    always_comb begin
        dec_op = OP_ILL;
        is_dop = 1'b1;
        case (ir_q[15:12])
            DOP_MOV: dec_op = OP_MOV;
            DOP_CMP: dec_op = OP_CMP;
            DOP_BIT: dec_op = OP_BIT;
            DOP_BIC: dec_op = OP_BIC;
            DOP_BIS: dec_op = OP_BIS;
            DOP_ADD: dec_op = OP_ADD;
            DOP_SUB: dec_op = OP_SUB;
            DOP_SOP: begin
                is_dop = 1'b0;
                case (ir_q[11:6])
                    SOP_CLR: dec_op = OP_CLR;
                    SOP_COM: dec_op = OP_COM;
                    SOP_INC: dec_op = OP_INC;
                    SOP_DEC: dec_op = OP_DEC;
                    SOP_NEG: dec_op = OP_NEG;
                    SOP_TST: dec_op = OP_TST;
                    default: dec_op = OP_ILL;
                endcase
            end
            default: dec_op = OP_ILL;
        endcase
        // register mode only, source field checked for double operand
        mode_ok = (ir_q[5:3] == 3'd0) && (!is_dop || ir_q[11:9] == 3'd0);
        if (!mode_ok) dec_op = OP_ILL;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ir_valid_q <= 1'b0;
            ex_valid_q <= 1'b0;
        end else begin
            ir_valid_q <= q_valid_i;
            ex_valid_q <= ir_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (q_valid_i) ir_q <= q_data_i;
        ex_op_q  <= dec_op;
        ex_src_q <= ir_q[8:6];
        ex_dst_q <= ir_q[2:0];
    end

    // ========================================
    // execute
    // ========================================

    assign src_val = regs[ex_src_q];
    assign dst_val = regs[ex_dst_q];

    always_comb begin
        alu_wide = '0;
        alu_res  = dst_val;
        c_new    = flags_q[FLAG_C];   // most ops leave C alone
        wr_en    = 1'b1;
        case (ex_op_q)
            OP_CLR: begin
                alu_res = '0;
                c_new   = 1'b0;
            end
            OP_COM: begin
                alu_res = ~dst_val;
                c_new   = 1'b1;
            end
            OP_INC: alu_res = dst_val + 16'd1;
            OP_DEC: alu_res = dst_val - 16'd1;
            OP_NEG: begin
                alu_res = -dst_val;
                c_new   = (alu_res != '0);
            end
            OP_TST: wr_en = 1'b0;
            OP_MOV: alu_res = src_val;
            OP_CMP: begin
                alu_wide = {1'b0, src_val} - {1'b0, dst_val};   // src - dst
                alu_res  = alu_wide[15:0];
                c_new    = alu_wide[16];
                wr_en    = 1'b0;
            end
            OP_BIT: begin
                alu_res = src_val & dst_val;
                wr_en   = 1'b0;
            end
            OP_BIC: alu_res = dst_val & ~src_val;
            OP_BIS: alu_res = dst_val | src_val;
            OP_ADD: begin
                alu_wide = {1'b0, src_val} + {1'b0, dst_val};
                alu_res  = alu_wide[15:0];
                c_new    = alu_wide[16];   // carry out
            end
            OP_SUB: begin
                alu_wide = {1'b0, dst_val} - {1'b0, src_val};   // dst - src
                alu_res  = alu_wide[15:0];
                c_new    = alu_wide[16];   // borrow
            end
            default: wr_en = 1'b0;   // illegal word
        endcase
    end

    assign legal       = ex_valid_q && (ex_op_q != OP_ILL);
    assign res_valid_o = legal;
    assign illegal_o   = ex_valid_q && (ex_op_q == OP_ILL);
    assign res_wr_o    = wr_en;
    assign res_reg_o   = ex_dst_q;
    assign res_data_o  = alu_res;
    assign res_flags_o = {alu_res[15], alu_res == '0, c_new};

    // register file and condition codes
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 8; i++) regs[i] <= '0;
            flags_q <= '0;
        end else if (legal) begin
            if (wr_en) regs[ex_dst_q] <= alu_res;
            flags_q <= res_flags_o;   // illegal words keep old flags
        end
    end

endmodule

// ==== rtl/insn_fetch.sv ====
module insn_fetch import cpu11_pkg::*; #(
    parameter int    QUEUE_DEPTH = QUEUE_DEPTH_DEF,
    parameter word_t BOOT_ADDR   = BOOT_ADDR_DEF
) (
    input  logic  clk,
    input  logic  reset_n,

    // word read bus
    output logic  rd_req_o,
    output word_t rd_addr_o,
    input  logic  rd_ready_i,
    input  word_t rd_data_i,

    // towards the instruction queue
    output logic  push_o,
    output word_t push_data_o,
    input  logic  credit_i
);

    localparam int CRED_W = $clog2(QUEUE_DEPTH + 1);

    logic [CRED_W-1:0] credit_q;
    logic [CRED_W-1:0] credit_d;
    logic              rd_req_q;
    word_t             pc_q;
    logic              reply;
    logic              req_start;

    // ========================================
    // bus handshake
    // ========================================

    assign reply = rd_req_q & rd_ready_i;  // data valid this cycle

    // new read only once the old reply is gone and a slot is free
    assign req_start = !rd_req_q && !rd_ready_i && (credit_q != '0);

    assign rd_req_o    = rd_req_q;
    assign rd_addr_o   = pc_q;      // held until reply
    assign push_o      = reply;
    assign push_data_o = rd_data_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_req_q <= 1'b0;
            pc_q     <= BOOT_ADDR;
        end else begin
            if (reply) begin
                rd_req_q <= 1'b0;            // at least one idle cycle
                pc_q     <= pc_q + 16'd2;    // next word
            end else if (req_start) begin
                rd_req_q <= 1'b1;
            end
        end
    end

    // ========================================
    // credit counter
    // ========================================

    // one credit spent per push, one back per pop in the queue
    always_comb begin
        credit_d = credit_q;
        if (push_o && !credit_i) begin
            credit_d = credit_q - 1'b1;
        end else if (!push_o && credit_i) begin
            credit_d = credit_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_q <= CRED_W'(QUEUE_DEPTH);   // queue starts empty
        end else begin
            credit_q <= credit_d;
        end
    end

endmodule

// ==== rtl/insn_queue.sv ====
module insn_queue import cpu11_pkg::*; #(
    parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
    input  logic  clk,
    input  logic  reset_n,

    // from fetch
    input  logic  push_i,
    input  word_t push_data_i,

    // to execute
    input  logic  pop_i,
    output logic  q_valid_o,
    output word_t q_data_o,

    // credit back to fetch
    output logic  credit_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    word_t             mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              pop_en;

    assign q_valid_o = (cnt_q != '0);
    assign q_data_o  = mem[rd_ptr_q];
    assign pop_en    = pop_i & q_valid_o;
    assign credit_o  = pop_en;   // one slot freed

    // storage, write side only
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // pointers wrap at QUEUE_DEPTH, which need not be a power of two
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) begin
                if (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) wr_ptr_q <= '0;
                else                                     wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_en) begin
                if (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) rd_ptr_q <= '0;
                else                                     rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_en})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;   // idle or push and pop together
            endcase
        end
    end

endmodule
